/* muldiv_cluster.f */
pip_types.sv
rob_types.sv
issue_if.sv
completion_if.sv
exmul.sv
ex_mul_wrapper.sv
issue_dispatch.sv
rob_writeback.sv
muldiv_cluster.sv
muldiv_cluster_tb.sv

/* Bender.yml */
package:
  name: muldiv_cluster

sources:
  - pip_types.sv
  - rob_types.sv
  - issue_if.sv
  - completion_if.sv
  - exmul.sv
  - ex_mul_wrapper.sv
  - issue_dispatch.sv
  - rob_writeback.sv
  - muldiv_cluster.sv
  - target: test
    files:
      - muldiv_cluster_tb.sv

/* muldiv_cluster_tb.sv */
`timescale 1ns/1ps

module muldiv_cluster_tb;
  import pip_types::*;
  import rob_types::*;

  localparam int N_SLOTS   = 1 << ROB_DEPTHLOG2;
  localparam int N_ISSUED  = 78;
  localparam int MAX_CYCLE = 40 * N_ISSUED + 200;

  logic        clock;
  logic        reset_n;
  logic        inst_valid;
  dec_inst_t   inst;
  logic [31:0] a;
  logic [31:0] b;
  rob_slot_t   rob_slot;
  logic        ready;
  logic        rob_data_valid;
  rob_slot_t   rob_data_idx;
  rob_entry_t  rob_data;

  // the scoreboard is indexed by reorder-buffer slot.
  rob_entry_t         exp_entry [N_SLOTS];
  int                 lat_exp   [N_SLOTS];
  int                 acc_cycle [N_SLOTS];
  logic [N_SLOTS-1:0] lat_chk = '0;
  logic [N_SLOTS-1:0] pending = '0;
  rob_slot_t          free_q [$];

  int          in_flight = 0;
  int          cycle = 0;
  int          errors = 0;
  int          err_mark = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  logic [31:0] rng = 32'h95ca;
  string       test_name = "reset";

  muldiv_cluster i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] t;
    t = s ^ (s << 13);
    t = t ^ (t >> 17);
    return t ^ (t << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // zero, the most negative value and minus one show up often.
  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = next_rand();
    case (r[2:0])
      3'd0:    return 32'd0;
      3'd1:    return 32'h8000_0000;
      3'd2:    return 32'hffff_ffff;
      default: return next_rand();
    endcase
  endfunction

  function automatic logic [31:0] model_result(muldiv_op_t op, logic [31:0] x, logic [31:0] y);
    logic [63:0] sprod;
    logic [63:0] uprod;
    logic [31:0] squo;
    logic [31:0] srem;
    logic        ovf;
    sprod = $signed({{32{x[31]}}, x}) * $signed({{32{y[31]}}, y});
    uprod = {32'd0, x} * {32'd0, y};
    ovf   = (x == 32'h8000_0000) && (y == 32'hffff_ffff);
    squo  = ovf ? x : 32'hffff_ffff;
    srem  = ovf ? 32'd0 : x;
    if (y != 32'd0 && !ovf) begin
      squo = $signed(x) / $signed(y);
      srem = $signed(x) % $signed(y);
    end
    case (op)
      OP_MUL:   return uprod[31:0];
      OP_MULH:  return sprod[63:32];
      OP_MULHU: return uprod[63:32];
      OP_DIV:   return squo;
      OP_DIVU:  return (y == 32'd0) ? 32'hffff_ffff : x / y;
      OP_REM:   return srem;
      OP_REMU:  return (y == 32'd0) ? x : x % y;
      default:  return 32'd0;
    endcase
  endfunction

  task automatic report(string msg);
    $display("%s", msg);
    errors++;
  endtask

  // accepts and writes as the DUT sees them at the clock edge.
  always @(posedge clock) begin
    cycle     <= cycle + 1;
    in_flight <= in_flight + int'(inst_valid && ready) - int'(rob_data_valid);
    if (inst_valid && ready) begin
      pending[rob_slot]   <= 1'b1;
      acc_cycle[rob_slot] <= cycle + 1;
    end
    if (rob_data_valid) begin
      pending[rob_data_idx] <= 1'b0;
      free_q.push_back(rob_data_idx);
    end
  end

  a_reset_state: assert property (@(posedge clock) $rose(reset_n) |-> ready && !rob_data_valid)
    else report("ready low or rob_data_valid high right after reset");

  // a lane freed at a grant edge is the one whose write is pulsing now.
  a_ready: assert property (@(posedge clock) disable iff (!reset_n)
    ready == ((in_flight - int'(rob_data_valid)) < N_LANES))
    else report($sformatf("MISMATCH %s: ready expected %b actual %b", test_name,
                          ($sampled(in_flight) - int'($sampled(rob_data_valid))) < N_LANES,
                          $sampled(ready)));

  a_known: assert property (@(posedge clock) disable iff (!reset_n)
    !$isunknown(rob_data_valid) && (!rob_data_valid || !$isunknown({rob_data_idx, rob_data})))
    else report("unknown value on the reorder-buffer write port");

  a_outstanding: assert property (@(posedge clock) disable iff (!reset_n)
    rob_data_valid |-> pending[rob_data_idx])
    else report($sformatf("write to slot %0d which has no outstanding instruction",
                          $sampled(rob_data_idx)));

  a_value: assert property (@(posedge clock) disable iff (!reset_n)
    rob_data_valid |-> rob_data == exp_entry[rob_data_idx])
    else report($sformatf("MISMATCH %s: slot %0d expected %h actual %h", test_name,
                          $sampled(rob_data_idx), exp_entry[$sampled(rob_data_idx)],
                          $sampled(rob_data)));

  a_latency: assert property (@(posedge clock) disable iff (!reset_n)
    rob_data_valid && lat_chk[rob_data_idx] |->
      cycle - acc_cycle[rob_data_idx] == lat_exp[rob_data_idx])
    else report($sformatf("MISMATCH %s: latency expected %0d actual %0d", test_name,
                          lat_exp[$sampled(rob_data_idx)],
                          $sampled(cycle) - acc_cycle[$sampled(rob_data_idx)]));

  task automatic issue(muldiv_op_t op, logic [31:0] x, logic [31:0] y, logic check_lat,
                       logic dv);
    rob_slot_t   slot;
    logic [31:0] r;
    logic        is_div;
    logic        accepted;
    while (free_q.size() == 0) begin
      @(posedge clock);
      #10;
    end
    slot   = free_q.pop_front();
    r      = next_rand();
    is_div = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    exp_entry[slot].result_lo      = model_result(op, x, y);
    exp_entry[slot].dest_reg       = r[4:0];
    exp_entry[slot].dest_reg_valid = dv && !(is_div && y == 32'd0);
    lat_exp[slot] = is_div ? 34 : 2;
    lat_chk[slot] = check_lat;
    inst.pc             = next_rand();
    inst.muldiv_op      = op;
    inst.dest_reg       = r[4:0];
    inst.dest_reg_valid = dv;
    a          = x;
    b          = y;
    rob_slot   = slot;
    inst_valid = 1'b1;
    do begin
      accepted = ready;
      @(posedge clock);
      #10;
    end while (!accepted);
    inst_valid = 1'b0;
  endtask

  task automatic drain();
    while (pending != '0) begin
      @(posedge clock);
      #10;
    end
  endtask

  task automatic start_test(string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic finish_test();
    drain();
    assert (free_q.size() == N_SLOTS)
      else report($sformatf("free list holds %0d slots after %s instead of %0d",
                            free_q.size(), test_name, N_SLOTS));
    if (errors == err_mark) begin
      tests_passed++;
      $display("%s: passed", test_name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", test_name, errors - err_mark);
    end
  endtask

  initial begin : watchdog
    wait (cycle >= MAX_CYCLE);
    $display("timeout after %0d cycles with results still outstanding", cycle);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int          i;
    muldiv_op_t  op;
    logic [31:0] x;
    logic [31:0] y;
    reset_n    = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    a          = 32'd0;
    b          = 32'd0;
    rob_slot   = '0;
    for (i = 0; i < N_SLOTS; i++)
      free_q.push_back(rob_slot_t'(i));
    repeat (4) @(posedge clock);
    #10;
    reset_n = 1'b1;

    start_test("latency");
    issue(OP_MUL, next_rand(), next_rand(), 1'b1, 1'b1);
    drain();
    issue(OP_DIV, next_rand(), 32'd3, 1'b1, 1'b1);
    finish_test();

    start_test("multiply");
    for (i = 0; i < 12; i++) begin
      x = next_rand();
      issue(muldiv_op_t'(1 + i % 3), pick_operand(), pick_operand(), 1'b0, x[0]);
    end
    finish_test();

    // the first four run the most negative value over minus one.
    start_test("divide");
    for (i = 0; i < 16; i++) begin
      x = (i < 4) ? 32'h8000_0000 : pick_operand();
      y = (i < 4) ? 32'hffff_ffff : pick_operand();
      issue(muldiv_op_t'(4 + i % 4), x, (y == 32'd0) ? 32'd7 : y, 1'b0, 1'b1);
    end
    finish_test();

    start_test("divide_by_zero");
    for (i = 0; i < 4; i++)
      issue(muldiv_op_t'(4 + i), pick_operand(), 32'd0, 1'b0, 1'b1);
    finish_test();

    // three divides fill the lanes, so the fourth waits for ready.
    start_test("back_to_back");
    for (i = 0; i < 4; i++)
      issue(OP_DIV, next_rand(), next_rand(), 1'b0, 1'b1);
    finish_test();

    start_test("random");
    for (i = 0; i < 40; i++) begin
      x  = next_rand();
      op = muldiv_op_t'(1 + x % 7);
      issue(op, pick_operand(), pick_operand(), 1'b0, x[3]);
    end
    finish_test();

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* muldiv_cluster.sv */
`timescale 1ns/1ps

module muldiv_cluster (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic                  inst_valid,
  input  pip_types::dec_inst_t  inst,
  input  logic [31:0]           a,
  input  logic [31:0]           b,
  input  rob_types::rob_slot_t  rob_slot,
  output logic                  ready,
  output logic                  rob_data_valid,
  output rob_types::rob_slot_t  rob_data_idx,
  output rob_types::rob_entry_t rob_data
);
  import pip_types::*;

  issue_if      lane_issue [N_LANES] ();
  completion_if lane_done  [N_LANES] ();

  issue_dispatch u_dispatch (
    .inst_valid (inst_valid),
    .inst       (inst),
    .a          (a),
    .b          (b),
    .rob_slot   (rob_slot),
    .ready      (ready),
    .lanes      (lane_issue)
  );

  for (genvar g = 0; g < N_LANES; g++) begin : g_lane
    ex_mul_wrapper u_lane (
      .clock   (clock),
      .reset_n (reset_n),
      .issue   (lane_issue[g]),
      .done    (lane_done[g])
    );
  end

  rob_writeback u_writeback (
    .clock          (clock),
    .reset_n        (reset_n),
    .done           (lane_done),
    .rob_data_valid (rob_data_valid),
    .rob_data_idx   (rob_data_idx),
    .rob_data       (rob_data)
  );

endmodule

/* rob_writeback.sv */
`timescale 1ns/1ps

module rob_writeback (
  input  logic                  clock,
  input  logic                  reset_n,
  completion_if.wb              done [pip_types::N_LANES],
  output logic                  rob_data_valid,
  output rob_types::rob_slot_t  rob_data_idx,
  output rob_types::rob_entry_t rob_data
);
  import pip_types::*;
  import rob_types::*;

  logic [N_LANES-1:0]    valid_vec;
  rob_slot_t             slot_arr  [N_LANES];
  rob_entry_t            entry_arr [N_LANES];
  logic [LANE_IDX_W-1:0] rr_ptr;
  logic [LANE_IDX_W-1:0] winner;
  logic                  any_valid;

  for (genvar i = 0; i < N_LANES; i++) begin : g_lane
    assign valid_vec[i]  = done[i].valid;
    assign slot_arr[i]   = done[i].rob_slot;
    assign entry_arr[i]  = done[i].entry;
    assign done[i].grant = any_valid & (winner == LANE_IDX_W'(i));
  end

  // search starts at the pointer and wraps around the lanes.
  always_comb begin
    int idx;
    any_valid = 1'b0;
    winner    = rr_ptr;
    for (int k = 0; k < N_LANES; k++) begin
      idx = (int'(rr_ptr) + k) % N_LANES;
      if (!any_valid && valid_vec[idx]) begin
        any_valid = 1'b1;
        winner    = LANE_IDX_W'(idx);
      end
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      rob_data_valid <= 1'b0;
      rr_ptr         <= '0;
    end else begin
      rob_data_valid <= any_valid;
      if (any_valid)
        rr_ptr <= (winner == LANE_IDX_W'(N_LANES - 1)) ? '0 : winner + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (any_valid) begin
      rob_data_idx <= slot_arr[winner];
      rob_data     <= entry_arr[winner];
    end
  end

endmodule

/* issue_dispatch.sv */
`timescale 1ns/1ps

module issue_dispatch (
  input  logic                 inst_valid,
  input  pip_types::dec_inst_t inst,
  input  logic [31:0]          a,
  input  logic [31:0]          b,
  input  rob_types::rob_slot_t rob_slot,
  output logic                 ready,
  issue_if.disp                lanes [pip_types::N_LANES]
);
  import pip_types::*;

  logic [N_LANES-1:0] idle_vec;
  logic [N_LANES-1:0] pick;

  // isolate the lowest set bit so only one lane sees valid.
  assign pick  = idle_vec & (~idle_vec + 1'b1);
  assign ready = |idle_vec;

  for (genvar i = 0; i < N_LANES; i++) begin : g_lane
    assign idle_vec[i]       = lanes[i].idle;
    assign lanes[i].valid    = inst_valid & pick[i];
    assign lanes[i].inst     = inst;
    assign lanes[i].a        = a;
    assign lanes[i].b        = b;
    assign lanes[i].rob_slot = rob_slot;
  end

endmodule

/* ex_mul_wrapper.sv */
`timescale 1ns/1ps

module ex_mul_wrapper (
  input  logic       clock,
  input  logic       reset_n,
  issue_if.lane      issue,
  completion_if.lane done
);
  import pip_types::*;
  import rob_types::*;

  dec_inst_t   inst_r;
  logic [31:0] a_r;
  logic [31:0] b_r;
  rob_slot_t   rob_slot_r;

  logic        occupied;
  logic        start_r;
  logic        held;
  logic        capture;
  logic        finish;

  muldiv_op_t  op;
  logic [31:0] result;
  logic        inval_dest_reg;
  logic        stall;
  rob_entry_t  entry;

  assign capture    = issue.valid & ~occupied;
  assign finish     = occupied & ~held & ~stall;
  assign issue.idle = ~occupied;

  // the engine sees no operation unless the lane holds an instruction.
  assign op = occupied ? inst_r.muldiv_op : OP_NONE;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      occupied <= 1'b0;
      start_r  <= 1'b0;
      held     <= 1'b0;
    end else begin
      start_r <= capture;
      if (capture)
        occupied <= 1'b1;
      else if (done.grant)
        occupied <= 1'b0;
      if (finish)
        held <= 1'b1;
      else if (done.grant)
        held <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      inst_r     <= issue.inst;
      a_r        <= issue.a;
      b_r        <= issue.b;
      rob_slot_r <= issue.rob_slot;
    end
  end

  exmul u_exmul (
    .clock          (clock),
    .reset_n        (reset_n),
    .start          (start_r),
    .op             (op),
    .a_val          (a_r),
    .b_val          (b_r),
    .result         (result),
    .inval_dest_reg (inval_dest_reg),
    .stall          (stall)
  );

  // the entry is formed from lane and engine state that stays put until the grant.
  assign entry.result_lo      = result;
  assign entry.dest_reg       = inst_r.dest_reg;
  assign entry.dest_reg_valid = inst_r.dest_reg_valid & ~inval_dest_reg;

  assign done.valid    = held;
  assign done.rob_slot = rob_slot_r;
  assign done.entry    = entry;

endmodule

/* exmul.sv */
`timescale 1ns/1ps

module exmul (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic                  start,
  input  pip_types::muldiv_op_t op,
  input  logic [31:0]           a_val,
  input  logic [31:0]           b_val,
  output logic [31:0]           result,
  output logic                  inval_dest_reg,
  output logic                  stall
);
  import pip_types::*;

  logic        is_div;
  logic        is_signed;
  logic        a_neg;
  logic        b_neg;
  logic [31:0] a_abs;
  logic [31:0] b_abs;
  logic [32:0] a_ext;
  logic [32:0] b_ext;
  logic [63:0] product;

  logic        busy;
  logic [4:0]  step;
  logic [4:0]  step_in;
  logic [31:0] rem_r;
  logic [31:0] quo_r;
  logic [31:0] rem_in;
  logic        dbit;
  logic [33:0] trial;

  logic        div_zero;
  logic        overflow;
  logic [31:0] quo_fix;
  logic [31:0] rem_fix;

  assign is_div    = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  assign is_signed = op inside {OP_DIV, OP_REM};
  assign a_neg     = is_signed & a_val[31];
  assign b_neg     = is_signed & b_val[31];
  assign a_abs     = a_neg ? -a_val : a_val;
  assign b_abs     = b_neg ? -b_val : b_val;

  // only MULH sign-extends. The low word is the same for signed and unsigned.
  assign a_ext   = {(op == OP_MULH) & a_val[31], a_val};
  assign b_ext   = {(op == OP_MULH) & b_val[31], b_val};
  assign product = $signed(a_ext) * $signed(b_ext);

  // the first step runs on the start edge, so 32 steps end one edge before completion.
  assign step_in = start ? 5'd0 : step;
  assign rem_in  = start ? 32'd0 : rem_r;
  assign dbit    = a_abs[5'd31 - step_in];
  assign trial   = {1'b0, rem_in, dbit} - {2'b00, b_abs};
  assign stall   = is_div & (start | busy);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      busy <= 1'b0;
      step <= 5'd0;
    end else if (stall) begin
      busy <= (step_in != 5'd31);
      step <= step_in + 5'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (stall) begin
      rem_r <= trial[33] ? {rem_in[30:0], dbit} : trial[31:0];
      quo_r <= {quo_r[30:0], ~trial[33]};
    end
  end

  assign div_zero = (b_val == 32'd0);
  assign overflow = is_signed & (a_val == 32'h8000_0000) & (b_val == 32'hffff_ffff);
  assign quo_fix  = (a_neg ^ b_neg) ? -quo_r : quo_r;
  assign rem_fix  = a_neg ? -rem_r : rem_r;

  always_comb begin
    case (op)
      OP_MUL:            result = product[31:0];
      OP_MULH, OP_MULHU: result = product[63:32];
      OP_DIV, OP_DIVU:   result = div_zero ? 32'hffff_ffff : (overflow ? a_val : quo_fix);
      OP_REM, OP_REMU:   result = div_zero ? a_val : (overflow ? 32'd0 : rem_fix);
      default:           result = 32'd0;
    endcase
  end

  assign inval_dest_reg = is_div & div_zero;

endmodule

/* completion_if.sv */
`timescale 1ns/1ps

interface completion_if;
  import rob_types::*;

  logic       valid;
  rob_slot_t  rob_slot;
  rob_entry_t entry;
  logic       grant;

  // valid and the data stay put until the edge where grant is high.
  modport lane (output valid, rob_slot, entry, input grant);
  modport wb   (input valid, rob_slot, entry, output grant);

endinterface

/* issue_if.sv */
`timescale 1ns/1ps

interface issue_if;
  import pip_types::*;
  import rob_types::*;

  logic        valid;
  dec_inst_t   inst;
  logic [31:0] a;
  logic [31:0] b;
  rob_slot_t   rob_slot;
  logic        idle;

  // the lane captures on any edge where valid and idle are both high.
  modport disp (output valid, inst, a, b, rob_slot, input idle);
  modport lane (input valid, inst, a, b, rob_slot, output idle);

endinterface

/* rob_types.sv */
package rob_types;

  localparam int ROB_DEPTHLOG2 = 4;

  typedef logic [ROB_DEPTHLOG2-1:0] rob_slot_t;

  // one reorder-buffer write as produced by the writeback stage.
  typedef struct packed {
    logic [31:0] result_lo;
    logic [4:0]  dest_reg;
    logic        dest_reg_valid;
  } rob_entry_t;

endpackage

/* pip_types.sv */
package pip_types;

  // number of identical multiply/divide lanes in the cluster.
  localparam int N_LANES = 3;

  // the round-robin pointer holds a lane index of this width.
  localparam int LANE_IDX_W = $clog2(N_LANES);

  typedef enum logic [2:0] {
    OP_NONE  = 3'd0,
    OP_MUL   = 3'd1,
    OP_MULH  = 3'd2,
    OP_MULHU = 3'd3,
    OP_DIV   = 3'd4,
    OP_DIVU  = 3'd5,
    OP_REM   = 3'd6,
    OP_REMU  = 3'd7
  } muldiv_op_t;

  // decoded instruction as seen by the multiply/divide cluster.
  typedef struct packed {
    logic [31:0] pc;
    muldiv_op_t  muldiv_op;
    logic [4:0]  dest_reg;
    logic        dest_reg_valid;
  } dec_inst_t;

endpackage
